// File: all.f
+incdir+include
source/uart_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/uart_tx.sv
source/uart_repeater.sv
sim/tb_uart_repeater.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the repeater testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
  --top-module tb_uart_repeater \
  --Mdir obj_dir -o tb_uart_repeater \
  -f all.f \
  && ./obj_dir/tb_uart_repeater | tee sim.log \
  || { echo "build or run failed"; exit 1; }

# a log without the fail message counts as a pass
grep -q "RESULT: FAIL" sim.log \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

// File: sim/tb_uart_repeater.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module tb_uart_repeater import uart_pkg::*; ();

  localparam int BAUD      = 15;
  localparam int BIT_CYC   = BAUD + 1;                      // cycles per bit
  localparam int FRAME_CYC = `UART_FRAME_BITS * BIT_CYC;
  localparam int N_FRAMES  = 1 + 20 + 3 + 8;                // frames over all tests
  localparam int LIMIT_CYC = 2 * N_FRAMES * FRAME_CYC + 40 * BIT_CYC;

  typedef uart_byte_t byte_q_t[$];

  logic                    clk;
  logic                    rst_n;
  logic [`UART_BAUD_W-1:0] baud;
  logic                    rx_line;
  logic                    cts_n;
  logic                    tx_line;
  logic                    tx_done;
  uart_status_t            status;

  uart_byte_t  exp_q[$];            // bytes still due on tx_line
  uart_byte_t  got_q[$];            // bytes decoded, not yet compared
  int          n_seen = 0;          // frames seen on tx_line
  int          errors = 0;
  logic [15:0] lfsr   = 16'd73;

  uart_repeater uart_repeater_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .baud    (baud),
    .rx_line (rx_line),
    .cts_n   (cts_n),
    .tx_line (tx_line),
    .tx_done (tx_done),
    .status  (status)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic uart_byte_t rand_byte();
    uart_byte_t b;
    b = '0;
    repeat (8) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  // start, 8 data bits lsb first, stop (low if bad_stop)
  task automatic send_frame(input uart_byte_t data, input bit bad_stop);
    logic [9:0] frame;
    int         i;
    frame = {~bad_stop, data, 1'b0};
    for (i = 0; i < `UART_FRAME_BITS; i++) begin
      @(posedge clk);
      rx_line <= frame[i];
      repeat (BIT_CYC - 1) @(posedge clk);
    end
  endtask

  task automatic idle_bits(input int n);
    @(posedge clk);
    rx_line <= 1'b1;
    repeat (n * BIT_CYC - 1) @(posedge clk);
  endtask

  // expected tx sequence: good bytes in order, bad frames gone,
  // a held transmitter keeps only what fits in the fifo
  function automatic byte_q_t expected_out(input uart_byte_t data[$], input bit bad[$],
                                           input bit hold);
    byte_q_t q;
    foreach (data[i]) begin
      if (bad[i])
        continue;
      if (hold && q.size() >= `UART_FIFO_DEPTH)
        continue;  // lost to overrun
      q.push_back(data[i]);
    end
    return q;
  endfunction

  task automatic queue_expected(input uart_byte_t data[$], input bit bad[$], input bit hold);
    byte_q_t e;
    e = expected_out(data, bad, hold);
    foreach (e[i])
      exp_q.push_back(e[i]);
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || got_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic wait_tx_done();
    int n;
    n = 0;
    while (!tx_done && n < 4 * BIT_CYC) begin
      @(negedge clk);
      n++;
    end
    assert (tx_done) else begin
      $display("ERROR: tx_done stayed low after the frame at %0t", $time);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitor and compare
  ////////////////////////////////////////////////////////////

  // tx_line moves on posedge, so look at it on negedge
  always begin : tx_monitor
    uart_byte_t b;
    @(negedge clk);
    if (!tx_line) begin
      repeat (BIT_CYC / 2) @(negedge clk);  // middle of start bit
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYC) @(negedge clk);
        b[i] = tx_line;
      end
      repeat (BIT_CYC) @(negedge clk);
      assert (tx_line) else begin
        $display("ERROR: stop bit low on tx_line at %0t", $time);
        errors++;
      end
      got_q.push_back(b);
      n_seen++;
    end
  end

  always @(negedge clk) begin : compare
    uart_byte_t got, want;
    if (got_q.size() != 0) begin
      got = got_q.pop_front();
      assert (exp_q.size() != 0) else begin
        $display("ERROR: byte %h came out on tx_line with none expected at %0t", got, $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (got == want) else begin
          $display("MISMATCH at %0t: tx_line byte expected %h got %h", $time, want, got);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (LIMIT_CYC) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles, %0d errors", LIMIT_CYC, errors);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  initial begin : tests
    uart_byte_t sent[$];
    bit         bad[$];
    int         seen_before;
    rst_n   = 1'b0;
    baud    = `UART_BAUD_W'(BAUD);
    rx_line = 1'b1;  // idle line
    cts_n   = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // 1 reset values
    @(negedge clk);
    assert (tx_line && !tx_done && status == '0) else begin
      $display("MISMATCH at %0t: tx_line/tx_done/status expected 1 0 00 got %b %b %b",
               $time, tx_line, tx_done, status);
      errors++;
    end

    // 2 single byte
    sent = '{8'hA5};
    bad  = '{1'b0};
    queue_expected(sent, bad, 1'b0);
    send_frame(sent[0], bad[0]);
    drain();
    wait_tx_done();

    // 3 twenty random bytes back to back
    sent.delete();
    bad.delete();
    repeat (20) begin
      sent.push_back(rand_byte());
      bad.push_back(1'b0);
    end
    queue_expected(sent, bad, 1'b0);
    foreach (sent[i])
      send_frame(sent[i], bad[i]);
    drain();
    assert (status == '0) else begin
      $display("MISMATCH at %0t: status expected 00 got %b", $time, status);
      errors++;
    end

    // 4 bad stop bit between two good frames
    sent = '{rand_byte(), rand_byte(), rand_byte()};
    bad  = '{1'b0, 1'b1, 1'b0};
    queue_expected(sent, bad, 1'b0);
    foreach (sent[i]) begin
      send_frame(sent[i], bad[i]);
      if (bad[i])
        idle_bits(2);  // let rx drop the false start in the low stop bit
    end
    drain();
    assert (status.frame_err) else begin
      $display("MISMATCH at %0t: status.frame_err expected 1 got 0", $time);
      errors++;
    end

    // 5 hold off with cts_n, fifo overflows
    sent.delete();
    bad.delete();
    repeat (8) begin
      sent.push_back(rand_byte());
      bad.push_back(1'b0);
    end
    queue_expected(sent, bad, 1'b1);
    @(posedge clk);
    cts_n <= 1'b1;
    seen_before = n_seen;
    foreach (sent[i])
      send_frame(sent[i], bad[i]);
    idle_bits(2);
    assert (n_seen == seen_before && tx_line) else begin
      $display("ERROR: tx_line sent a frame while cts_n was high at %0t", $time);
      errors++;
    end
    assert (status.overrun) else begin
      $display("MISMATCH at %0t: status.overrun expected 1 got 0", $time);
      errors++;
    end
    @(posedge clk);
    cts_n <= 1'b0;
    drain();
    idle_bits(`UART_FRAME_BITS + 2);  // long enough for a stray frame to be decoded

    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: source/uart_repeater.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_repeater import uart_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`UART_BAUD_W-1:0] baud,     // bit period minus one
  input  logic                    rx_line,  // serial in, idle high
  input  logic                    cts_n,    // high means hold
  output logic                    tx_line,  // serial out
  output logic                    tx_done,
  output uart_status_t            status    // sticky error flags
);

  logic       rx_push;       // receiver to fifo
  uart_byte_t rx_data;
  logic       rx_frame_err;
  logic       fifo_avail;    // fifo to transmitter
  uart_byte_t fifo_head;
  logic       fifo_overrun;
  logic       tx_pop;

  ////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////
  uart_rx rx_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .baud      (baud),
    .rx_line   (rx_line),
    .push      (rx_push),
    .rx_byte   (rx_data),
    .frame_err (rx_frame_err)
  );

  byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (rx_push),
    .din     (rx_data),
    .pop     (tx_pop),
    .avail   (fifo_avail),
    .head    (fifo_head),
    .overrun (fifo_overrun)
  );

  ////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////
  uart_tx tx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .baud    (baud),
    .avail   (fifo_avail),
    .head    (fifo_head),
    .cts_n   (cts_n),
    .pop     (tx_pop),
    .tx_line (tx_line),
    .tx_done (tx_done)
  );

  assign status = '{frame_err: rx_frame_err, overrun: fifo_overrun};

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`UART_BAUD_W-1:0] baud,     // bit period minus one
  input  logic                    avail,    // fifo holds a byte
  input  uart_byte_t              head,     // byte to send next
  input  logic                    cts_n,    // high holds off a new frame
  output logic                    pop,      // strobe, same cycle as load
  output logic                    tx_line,  // serial out, idle high
  output logic                    tx_done   // high between frames
);

  uart_state_t             state, nxt_state;
  logic [8:0]              shift_reg;  // data plus start bit
  logic [3:0]              bit_cnt;    // bits shifted out so far
  logic [`UART_BAUD_W-1:0] baud_cnt;   // cycles left in this bit
  logic                    load, sending, shift;
  logic                    go;         // byte ready and far side willing
  logic                    frame_end;  // stop bit done

  assign go        = avail && !cts_n;
  assign frame_end = (bit_cnt == 4'(`UART_FRAME_BITS));
  assign shift     = sending && !frame_end && (baud_cnt == '0);
  assign pop       = load;
  assign tx_line   = shift_reg[0];

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (load || shift)
      baud_cnt <= baud;             // fresh bit period
    else if (sending)
      baud_cnt <= baud_cnt - 1'b1;  // idle counter stays frozen
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (load)
      bit_cnt <= '0;
    else if (shift)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      shift_reg <= `UART_TX_SHIFT_RST;
    else if (load)
      shift_reg <= {head, 1'b0};                // start bit goes out first
    else if (shift)
      shift_reg <= {1'b1, shift_reg[8:1]};      // ones fill in as stop and idle
  end

  // set at the end of a frame, cleared by the next load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      tx_done <= 1'b0;
    else if (load)
      tx_done <= 1'b0;
    else if (frame_end)
      tx_done <= 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    load      = 1'b0;
    sending   = 1'b0;
    case (state)
      IDLE: begin
        if (go) begin
          load      = 1'b1;
          nxt_state = DATA;
        end
      end
      DATA: begin
        sending = 1'b1;
        if (frame_end) begin
          if (go)
            load = 1'b1;       // chain the next frame, one idle cycle
          else
            nxt_state = IDLE;
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module byte_fifo import uart_pkg::*; #(
  parameter int DEPTH = `UART_FIFO_DEPTH  // power of two
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,     // always taken, dropped if full
  input  uart_byte_t din,
  input  logic       pop,      // only while avail
  output logic       avail,    // not empty
  output uart_byte_t head,     // oldest byte, valid with avail
  output logic       overrun   // sticky drop flag
);

  localparam int AW = $clog2(DEPTH);

  uart_byte_t     mem [DEPTH];
  logic [AW-1:0]  wr_ptr, rd_ptr;  // wrap on their own
  logic [AW:0]    count;           // occupancy 0..DEPTH
  logic           full;
  logic           do_push, do_pop;

  assign full    = (count == (AW+1)'(DEPTH));
  assign do_pop  = pop && avail;
  assign do_push = push && (!full || do_pop);  // a pop frees the slot this cycle

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  assign head  = mem[rd_ptr];  // first word falls through
  assign avail = (count != '0);

  ////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
      if (push && !do_push)
        overrun <= 1'b1;  // byte lost
    end
  end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`UART_BAUD_W-1:0] baud,      // bit period minus one
  input  logic                    rx_line,   // raw serial in, idle high
  output logic                    push,      // one cycle strobe with rx_byte
  output uart_byte_t              rx_byte,   // last good byte
  output logic                    frame_err  // sticky
);

  uart_state_t             state, nxt_state;
  logic                    rx_meta, rx_sync;  // two flop synchronizer
  logic [`UART_BAUD_W-1:0] baud_cnt;          // counts down to the next sample
  logic [3:0]              bit_cnt;           // samples taken in this frame
  uart_byte_t              shift_reg;         // data bits, lsb arrives first
  logic                    arm;               // start edge seen
  logic                    sample;            // middle of the current bit
  logic                    last_bit;          // this sample is the stop bit
  logic                    stop_ok, stop_bad;

  ////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= `UART_LINE_IDLE;
      rx_sync <= `UART_LINE_IDLE;
    end else begin
      rx_meta <= rx_line;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////
  // bit timing
  ////////////////////////////////////////////////////////////
  assign sample   = (state != IDLE) && (baud_cnt == '0);
  assign last_bit = (bit_cnt == 4'(`UART_FRAME_BITS - 1));
  assign stop_ok  = sample && (state == DATA) && last_bit && rx_sync;
  assign stop_bad = sample && (state == DATA) && last_bit && !rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (arm)
      baud_cnt <= {1'b0, baud[`UART_BAUD_W-1:1]};  // half period to mid start bit
    else if (sample)
      baud_cnt <= baud;                             // full period to next middle
    else if (state != IDLE)
      baud_cnt <= baud_cnt - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (arm)
      bit_cnt <= '0;
    else if (sample)
      bit_cnt <= bit_cnt + 1'b1;  // start sample makes it 1
  end

  // payload only, shifted in from the msb end on data samples
  always_ff @(posedge clk) begin
    if (sample && (state == DATA) && !last_bit)
      shift_reg <= {rx_sync, shift_reg[7:1]};
  end

  assign rx_byte = shift_reg;

  ////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    arm       = 1'b0;
    case (state)
      IDLE: begin
        if (!rx_sync) begin  // falling edge of a start bit
          arm       = 1'b1;
          nxt_state = START;
        end
      end
      START: begin
        if (sample)
          nxt_state = rx_sync ? IDLE : DATA;  // high again means glitch
      end
      DATA: begin
        if (sample && last_bit)
          nxt_state = IDLE;
      end
      default: nxt_state = IDLE;
    endcase
  end

  // push lands one cycle after the stop sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push      <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      push <= stop_ok;
      if (stop_bad)
        frame_err <= 1'b1;  // held until reset
    end
  end

endmodule

// File: source/uart_pkg.sv
package uart_pkg;

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  // one data byte as carried on the line and in the fifo
  typedef logic [7:0] uart_byte_t;

  ////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////

  // sticky error flags seen at the top level
  typedef struct packed {
    logic frame_err;  // stop bit sampled low
    logic overrun;    // byte lost to a full fifo
  } uart_status_t;

  ////////////////////////////////////////////////////////////
  // fsm encoding
  ////////////////////////////////////////////////////////////

  // rx walks all three states
  // tx only uses IDLE and DATA
  typedef enum logic [1:0] {
    IDLE  = 2'b00,  // line quiet
    START = 2'b01,  // checking the start bit
    DATA  = 2'b10   // data and stop bits
  } uart_state_t;

endpackage

// File: include/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// fifo depth in bytes, keep it a power of two
`define UART_FIFO_DEPTH 4

// start + 8 data + stop
`define UART_FRAME_BITS 10

// width of the run time baud divisor
`define UART_BAUD_W 13

// reset values
`define UART_LINE_IDLE    1'b1   // serial line rests high
`define UART_TX_SHIFT_RST 9'h1FF // tx shifter full of idle bits

`endif
